//--- rtl/opl3_pkg.sv
// register map, field widths and packed structs shared by the opl3 register block; import it
package opl3_pkg;
    // register array shape
    localparam int NUM_BANKS           = 2;   // bank 0 = opl2 set, bank 1 = opl3 extension
    localparam int NUM_REG_PER_BANK    = 256;
    localparam int REG_FILE_DATA_WIDTH = 8;

    localparam int NUM_OPERATORS = 18; // per bank
    localparam int NUM_CHANNELS  = 9;  // per bank

    // decoded field widths
    localparam int REG_TIMER_WIDTH          = 8;
    localparam int REG_FNUM_WIDTH           = 10;
    localparam int REG_MULT_WIDTH           = 4;
    localparam int REG_BLOCK_WIDTH          = 3;
    localparam int REG_WS_WIDTH             = 3;
    localparam int REG_ENV_WIDTH            = 4;
    localparam int REG_TL_WIDTH             = 6;
    localparam int REG_KSL_WIDTH            = 2;
    localparam int REG_FB_WIDTH             = 3;
    localparam int REG_CONNECTION_SEL_WIDTH = 6;

    typedef logic [$clog2(NUM_REG_PER_BANK)-1:0] reg_addr_t;
    typedef logic [REG_FILE_DATA_WIDTH-1:0]      reg_data_t;

    // global registers
    localparam reg_addr_t ADDR_TIMER1     = 8'h02;
    localparam reg_addr_t ADDR_TIMER2     = 8'h03;
    localparam reg_addr_t ADDR_TIMER_CTRL = 8'h04; // also connection_sel in bank 1
    localparam reg_addr_t ADDR_NEW        = 8'h05; // bank 1 only
    localparam reg_addr_t ADDR_NTS        = 8'h08;
    localparam reg_addr_t ADDR_RHYTHM     = 8'hBD;

    // operator bases, slot index added on top
    localparam reg_addr_t ADDR_OP_AM_VIB = 8'h20;
    localparam reg_addr_t ADDR_OP_KSL_TL = 8'h40;
    localparam reg_addr_t ADDR_OP_AR_DR  = 8'h60;
    localparam reg_addr_t ADDR_OP_SL_RR  = 8'h80;
    localparam reg_addr_t ADDR_OP_WS     = 8'hE0;

    // channel bases, channel index added on top
    localparam reg_addr_t ADDR_CH_FNUM_LO  = 8'hA0;
    localparam reg_addr_t ADDR_CH_KON_BLK  = 8'hB0;
    localparam reg_addr_t ADDR_CH_FB_CNT   = 8'hC0;

    // one host access, held stable while req is high
    typedef struct packed {
        logic      we;    // 1 = write, 0 = status read
        logic      bank;
        reg_addr_t addr;
        reg_data_t wdata;
    } host_req_t;

    typedef struct packed {
        logic                      am;   // tremolo enable
        logic                      vib;  // vibrato enable
        logic                      egt;  // sustaining envelope
        logic                      ksr;  // key scale rate
        logic [REG_MULT_WIDTH-1:0] mult;
        logic [REG_KSL_WIDTH-1:0]  ksl;  // key scale level
        logic [REG_TL_WIDTH-1:0]   tl;   // total level (attenuation)
        logic [REG_ENV_WIDTH-1:0]  ar;
        logic [REG_ENV_WIDTH-1:0]  dr;
        logic [REG_ENV_WIDTH-1:0]  sl;
        logic [REG_ENV_WIDTH-1:0]  rr;
        logic [REG_WS_WIDTH-1:0]   ws;   // waveform select
    } op_params_t;

    typedef struct packed {
        logic [REG_FNUM_WIDTH-1:0]  fnum;
        logic [REG_BLOCK_WIDTH-1:0] block; // octave
        logic                       kon;   // key on
        logic                       cha;   // output routing a..d
        logic                       chb;
        logic                       chc;
        logic                       chd;
        logic [REG_FB_WIDTH-1:0]    fb;    // modulator feedback
        logic                       cnt;   // fm / am connection
    } ch_params_t;

    typedef struct packed {
        logic [REG_TIMER_WIDTH-1:0]          timer1;
        logic [REG_TIMER_WIDTH-1:0]          timer2;
        logic                                mt1;    // flag masks
        logic                                mt2;
        logic                                st1;    // timer starts
        logic                                st2;
        logic [REG_CONNECTION_SEL_WIDTH-1:0] connection_sel; // 4-op pairing
        logic                                is_new; // opl3 mode
        logic                                nts;    // keyboard split
        logic                                dam;    // tremolo depth
        logic                                dvb;    // vibrato depth
        logic                                ryt;    // rhythm mode
        logic                                bd;
        logic                                sd;
        logic                                tom;
        logic                                tc;
        logic                                hh;
    } global_params_t;
endpackage

//--- rtl/host_if_ctrl.sv
// host req/ack handshake controller; turns each accepted access into a write strobe or a status read
`timescale 1ns/1ps

module host_if_ctrl
    import opl3_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req,      // four-phase request
    input  host_req_t host_req, // stable while req high
    output logic      ack,
    output reg_data_t rdata,    // valid while ack high
    input  reg_data_t status,
    output logic      wr_en,    // one clock per write
    output logic      flag_clr, // timer flag reset instead of a write
    output logic      wr_bank,
    output reg_addr_t wr_addr,
    output reg_data_t wr_data
);
    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_ACK  = 1'b1
    } state_t;

    state_t state;
    logic   req_q;       // req from last clock
    logic   req_rise;
    logic   accept;      // start of a new access
    logic   is_flag_rst; // bank 0 reg 04 write with bit 7 set

    assign req_rise    = req && !req_q;
    assign accept      = (state == ST_IDLE) && req_rise;
    assign is_flag_rst = host_req.we && !host_req.bank &&
                         (host_req.addr == ADDR_TIMER_CTRL) && host_req.wdata[7];
    assign ack         = (state == ST_ACK); // straight from the state flop

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            req_q    <= 1'b0;
            wr_en    <= 1'b0;
            flag_clr <= 1'b0;
        end else begin
            req_q    <= req;
            wr_en    <= accept && host_req.we && !is_flag_rst; // reg 04 keeps old value
            flag_clr <= accept && is_flag_rst;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_ACK; // access done in this clock
                    end
                end
                ST_ACK: begin
                    if (!req) begin
                        state <= ST_IDLE; // host released
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // access payload, loaded once per request
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_bank <= host_req.bank;
            wr_addr <= host_req.addr;
            wr_data <= host_req.wdata;
            if (!host_req.we) begin
                rdata <= status; // reads always return status
            end
        end
    end
endmodule

//--- rtl/reg_store.sv
// raw register image of both banks; written one byte per strobe and driven out whole
`timescale 1ns/1ps

module reg_store
    import opl3_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wr_en,   // one clock per host write
    input  logic      wr_bank,
    input  reg_addr_t wr_addr,
    input  reg_data_t wr_data,
    output reg_data_t opl3_reg [NUM_BANKS][NUM_REG_PER_BANK] // full image to decode
);
    // all 512 bytes read as zero after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int a = 0; a < NUM_REG_PER_BANK; a++) begin
                    opl3_reg[b][a] <= '0;
                end
            end
        end else if (wr_en) begin
            opl3_reg[wr_bank][wr_addr] <= wr_data; // visible next clock
        end
    end
endmodule

//--- rtl/register_file.sv
// combinational decode of the raw register image into operator, channel and global fields
`timescale 1ns/1ps

module register_file
    import opl3_pkg::*;
(
    input  reg_data_t      opl3_reg  [NUM_BANKS][NUM_REG_PER_BANK],
    input  logic           irq,
    input  logic           ft1,
    input  logic           ft2,
    output op_params_t     op_params [NUM_BANKS][NUM_OPERATORS],
    output ch_params_t     ch_params [NUM_BANKS][NUM_CHANNELS],
    output global_params_t glob,
    output reg_data_t      status    // host read value
);
    localparam int NUM_OP_SLOTS = 22; // 0-21, slots 6,7,14,15 unused

    for (genvar bank = 0; bank < NUM_BANKS; bank++) begin : g_bank
        for (genvar slot = 0; slot < NUM_OP_SLOTS; slot++) begin : g_slot
            if ((slot % 8) < 6) begin : g_op
                localparam int OP = slot - 2 * (slot / 8); // 8-13 -> 6-11, 16-21 -> 12-17

                reg_data_t am_vib;
                reg_data_t ksl_tl;
                reg_data_t ar_dr;
                reg_data_t sl_rr;
                reg_data_t wave;

                assign am_vib = opl3_reg[bank][ADDR_OP_AM_VIB + slot];
                assign ksl_tl = opl3_reg[bank][ADDR_OP_KSL_TL + slot];
                assign ar_dr  = opl3_reg[bank][ADDR_OP_AR_DR + slot];
                assign sl_rr  = opl3_reg[bank][ADDR_OP_SL_RR + slot];
                assign wave   = opl3_reg[bank][ADDR_OP_WS + slot];

                always_comb begin
                    op_params[bank][OP].am   = am_vib[7];
                    op_params[bank][OP].vib  = am_vib[6];
                    op_params[bank][OP].egt  = am_vib[5];
                    op_params[bank][OP].ksr  = am_vib[4];
                    op_params[bank][OP].mult = am_vib[3:0];
                    op_params[bank][OP].ksl  = ksl_tl[7:6];
                    op_params[bank][OP].tl   = ksl_tl[5:0];
                    op_params[bank][OP].ar   = ar_dr[7:4];
                    op_params[bank][OP].dr   = ar_dr[3:0];
                    op_params[bank][OP].sl   = sl_rr[7:4];
                    op_params[bank][OP].rr   = sl_rr[3:0];
                    op_params[bank][OP].ws   = wave[2:0]; // bit 2 only meaningful in opl3 mode
                end
            end
        end

        for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_ch
            reg_data_t fnum_lo;
            reg_data_t kon_blk;
            reg_data_t fb_cnt;

            assign fnum_lo = opl3_reg[bank][ADDR_CH_FNUM_LO + ch];
            assign kon_blk = opl3_reg[bank][ADDR_CH_KON_BLK + ch];
            assign fb_cnt  = opl3_reg[bank][ADDR_CH_FB_CNT + ch];

            always_comb begin
                ch_params[bank][ch].fnum  = {kon_blk[1:0], fnum_lo}; // top 2 bits live in B0
                ch_params[bank][ch].kon   = kon_blk[5];
                ch_params[bank][ch].block = kon_blk[4:2];
                ch_params[bank][ch].chd   = fb_cnt[7];
                ch_params[bank][ch].chc   = fb_cnt[6];
                ch_params[bank][ch].chb   = fb_cnt[5];
                ch_params[bank][ch].cha   = fb_cnt[4];
                ch_params[bank][ch].fb    = fb_cnt[3:1];
                ch_params[bank][ch].cnt   = fb_cnt[0];
            end
        end
    end

    // chip-wide fields, bank 0 unless noted
    always_comb begin
        glob.timer1         = opl3_reg[0][ADDR_TIMER1];
        glob.timer2         = opl3_reg[0][ADDR_TIMER2];
        glob.mt1            = opl3_reg[0][ADDR_TIMER_CTRL][6];
        glob.mt2            = opl3_reg[0][ADDR_TIMER_CTRL][5];
        glob.st2            = opl3_reg[0][ADDR_TIMER_CTRL][1];
        glob.st1            = opl3_reg[0][ADDR_TIMER_CTRL][0];
        glob.connection_sel = opl3_reg[1][ADDR_TIMER_CTRL][REG_CONNECTION_SEL_WIDTH-1:0]; // bank 1
        glob.is_new         = opl3_reg[1][ADDR_NEW][0]; // bank 1
        glob.nts            = opl3_reg[0][ADDR_NTS][6];
        glob.dam            = opl3_reg[0][ADDR_RHYTHM][7];
        glob.dvb            = opl3_reg[0][ADDR_RHYTHM][6];
        glob.ryt            = opl3_reg[0][ADDR_RHYTHM][5];
        glob.bd             = opl3_reg[0][ADDR_RHYTHM][4];
        glob.sd             = opl3_reg[0][ADDR_RHYTHM][3];
        glob.tom            = opl3_reg[0][ADDR_RHYTHM][2];
        glob.tc             = opl3_reg[0][ADDR_RHYTHM][1];
        glob.hh             = opl3_reg[0][ADDR_RHYTHM][0];
    end

    // status byte, low five bits read zero
    always_comb begin
        status    = '0;
        status[7] = irq;
        status[6] = ft1;
        status[5] = ft2;
    end
endmodule

//--- rtl/opl3_timers.sv
// the two chip timers; base-tick prescaler, reloading counters, maskable overflow flags and irq
`timescale 1ns/1ps

module opl3_timers
    import opl3_pkg::*;
#(
    parameter int TICK_DIV = 4 // clocks per 80 us base tick
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [REG_TIMER_WIDTH-1:0] timer1,   // reload values
    input  logic [REG_TIMER_WIDTH-1:0] timer2,
    input  logic                       mt1,      // flag masks
    input  logic                       mt2,
    input  logic                       st1,      // run enables
    input  logic                       st2,
    input  logic                       flag_clr, // clears both flags
    output logic                       ft1,
    output logic                       ft2,
    output logic                       irq
);
    localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             base_tick; // timer 1 rate
    logic [1:0]       quad_cnt;
    logic             t2_tick;   // timer 2 rate, base / 4

    logic [1:0][REG_TIMER_WIDTH-1:0] load_val; // per timer
    logic [1:0]                      mask;
    logic [1:0]                      start;
    logic [1:0]                      step;

    assign base_tick = (div_cnt == DIV_W'(TICK_DIV - 1));
    assign t2_tick   = base_tick && (quad_cnt == 2'd3);

    assign load_val = {timer2, timer1};
    assign mask     = {mt2, mt1};
    assign start    = {st2, st1};
    assign step     = {t2_tick, base_tick};

    // free-running prescaler
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt  <= '0;
            quad_cnt <= '0;
        end else if (base_tick) begin
            div_cnt  <= '0;
            quad_cnt <= quad_cnt + 2'd1; // wraps every 4 ticks
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    for (genvar t = 0; t < 2; t++) begin : g_timer
        logic [REG_TIMER_WIDTH-1:0] count;
        logic                       start_q; // for start edge
        logic                       flag;    // sticky overflow

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                count   <= '0;
                start_q <= 1'b0;
                flag    <= 1'b0;
            end else begin
                start_q <= start[t];
                if (start[t] && !start_q) begin
                    count <= load_val[t]; // load on start edge
                end else if (start[t] && step[t]) begin
                    if (count == '1) begin
                        count <= load_val[t]; // overflow past 255
                        if (!mask[t]) begin
                            flag <= 1'b1;
                        end
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                if (flag_clr) begin
                    flag <= 1'b0; // host reset wins
                end
            end
        end
    end

    assign ft1 = g_timer[0].flag;
    assign ft2 = g_timer[1].flag;
    assign irq = ft1 || ft2;
endmodule

//--- rtl/opl3_regs_top.sv
// top of the opl3 register block; host port in, decoded fields and irq out to the sound core
`timescale 1ns/1ps

module opl3_regs_top
    import opl3_pkg::*;
#(
    parameter int TICK_DIV = 4 // small value for simulation
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           req,
    input  host_req_t      host_req,
    output logic           ack,
    output reg_data_t      rdata,
    output op_params_t     op_params [NUM_BANKS][NUM_OPERATORS],
    output ch_params_t     ch_params [NUM_BANKS][NUM_CHANNELS],
    output global_params_t glob,
    output logic           irq
);
    logic      wr_en;
    logic      flag_clr;
    logic      wr_bank;
    reg_addr_t wr_addr;
    reg_data_t wr_data;
    reg_data_t opl3_reg [NUM_BANKS][NUM_REG_PER_BANK];
    reg_data_t status;
    logic      ft1;
    logic      ft2;

    host_if_ctrl u_host_if_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .host_req (host_req),
        .ack      (ack),
        .rdata    (rdata),
        .status   (status),
        .wr_en    (wr_en),
        .flag_clr (flag_clr),
        .wr_bank  (wr_bank),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    reg_store u_reg_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_bank  (wr_bank),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .opl3_reg (opl3_reg)
    );

    register_file u_register_file (
        .opl3_reg  (opl3_reg),
        .irq       (irq),
        .ft1       (ft1),
        .ft2       (ft2),
        .op_params (op_params),
        .ch_params (ch_params),
        .glob      (glob),
        .status    (status)
    );

    opl3_timers #(
        .TICK_DIV (TICK_DIV)
    ) u_opl3_timers (
        .clk      (clk),
        .rst_n    (rst_n),
        .timer1   (glob.timer1), // timer controls come from the decode
        .timer2   (glob.timer2),
        .mt1      (glob.mt1),
        .mt2      (glob.mt2),
        .st1      (glob.st1),
        .st2      (glob.st2),
        .flag_clr (flag_clr),
        .ft1      (ft1),
        .ft2      (ft2),
        .irq      (irq)
    );
endmodule

//--- testbench/opl3_regs_assert.sv
// handshake and flag-reset checks on the host controller; attached to host_if_ctrl with bind
`timescale 1ns/1ps

module opl3_regs_assert (
    input logic clk,
    input logic rst_n,
    input logic req,
    input logic ack,
    input logic wr_en,
    input logic flag_clr
);
    property p_ack_rise;
        @(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req); // answers a held req
    endproperty

    property p_ack_fall;
        @(posedge clk) disable iff (!rst_n) $fell(ack) |-> !$past(req); // host released first
    endproperty

    // a strobe only starts an access, and a flag reset replaces the register write
    property p_strobe_excl;
        @(posedge clk) disable iff (!rst_n)
            (wr_en || flag_clr) |-> $rose(ack) && !(wr_en && flag_clr);
    endproperty

    a_ack_rise: assert property (p_ack_rise) else $error("ack rose while req was low");
    a_ack_fall: assert property (p_ack_fall) else $error("ack fell while req was still high");
    a_strobe_excl: assert property (p_strobe_excl)
        else $error("wr_en or flag_clr outside an access start, or both together");
endmodule

bind host_if_ctrl opl3_regs_assert u_opl3_regs_assert (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .ack      (ack),
    .wr_en    (wr_en),
    .flag_clr (flag_clr)
);

//--- testbench/tb_opl3_regs.sv
// directed testbench for the opl3 register block; drives the host port, checks decode, timers, status
`timescale 1ns/1ps

module tb_opl3_regs;
    import opl3_pkg::*;

    localparam int TICK_DIV    = 4;
    localparam int ACK_TIMEOUT = 20; // clocks per handshake phase
    localparam reg_addr_t OP_BASE [5] = '{8'h20, 8'h40, 8'h60, 8'h80, 8'hE0};
    localparam reg_addr_t CH_BASE [3] = '{8'hA0, 8'hB0, 8'hC0};

    logic           clk;
    logic           rst_n;
    logic           req;
    host_req_t      host_req;
    logic           ack;
    reg_data_t      rdata;
    op_params_t     op_params [NUM_BANKS][NUM_OPERATORS];
    ch_params_t     ch_params [NUM_BANKS][NUM_CHANNELS];
    global_params_t glob;
    logic           irq;
    int             err_cnt;
    int             timeout_cnt;
    int             chk_cnt;
    int unsigned    seed;

    opl3_regs_top #(.TICK_DIV(TICK_DIV)) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .host_req  (host_req),
        .ack       (ack),
        .rdata     (rdata),
        .op_params (op_params),
        .ch_params (ch_params),
        .glob      (glob),
        .irq       (irq)
    );

    always #10 clk = ~clk; // 20 ns period

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (ack !== level && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (ack !== level) begin
            timeout_cnt++;
            $display("timeout at %0t: ack never went to %0b", $time, level);
        end
    endtask

    task automatic wait_irq(input int bound, input string what);
        int n;
        n = 0;
        while (irq !== 1'b1 && n < bound) begin
            @(negedge clk);
            n++;
        end
        if (irq !== 1'b1) begin
            timeout_cnt++;
            $display("timeout at %0t: %s never raised irq", $time, what);
        end
    endtask

    // one full four-phase access, inputs change on falling edges only
    task automatic host_access(input logic we, input logic bank, input reg_addr_t addr,
                               input reg_data_t data, output reg_data_t rd);
        @(negedge clk);
        host_req = '{we: we, bank: bank, addr: addr, wdata: data};
        req      = 1'b1;
        @(negedge clk);
        wait_ack(1'b1);
        rd  = rdata; // valid while ack high
        req = 1'b0;
        @(negedge clk);
        wait_ack(1'b0);
    endtask

    task automatic host_write(input logic bank, input reg_addr_t addr, input reg_data_t data);
        reg_data_t unused_rd;
        host_access(1'b1, bank, addr, data, unused_rd);
    endtask

    task automatic host_read(output reg_data_t rd);
        host_access(1'b0, 1'b0, 8'h00, 8'h00, rd);
    endtask

    task automatic test_reset();
        reg_data_t rd;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int o = 0; o < NUM_OPERATORS; o++) begin
                check_val($sformatf("op_params[%0d][%0d]", b, o), 64'(op_params[b][o]), 64'd0);
            end
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                check_val($sformatf("ch_params[%0d][%0d]", b, c), 64'(ch_params[b][c]), 64'd0);
            end
        end
        check_val("glob", 64'(glob), 64'd0);
        check_val("irq", 64'(irq), 64'd0);
        host_read(rd);
        check_val("rdata", 64'(rd), 64'd0);
    endtask

    task automatic test_op_map();
        reg_data_t  v [5];
        op_params_t exp;
        int         op;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int slot = 0; slot < 22; slot++) begin
                if (slot % 8 < 6) begin // slots 6,7 of each group unused
                    op = slot - 2 * (slot / 8);
                    for (int i = 0; i < 5; i++) begin
                        v[i] = reg_data_t'($urandom);
                        host_write(1'(b), OP_BASE[i] + reg_addr_t'(slot), v[i]);
                    end
                    exp = '{am: v[0][7], vib: v[0][6], egt: v[0][5], ksr: v[0][4],
                            mult: v[0][3:0], ksl: v[1][7:6], tl: v[1][5:0],
                            ar: v[2][7:4], dr: v[2][3:0], sl: v[3][7:4], rr: v[3][3:0],
                            ws: v[4][2:0]};
                    check_val($sformatf("op_params[%0d][%0d]", b, op),
                              64'(op_params[b][op]), 64'(exp));
                end
            end
        end
    endtask

    task automatic test_ch_glob();
        reg_data_t      v [3];
        reg_data_t      g [7];
        ch_params_t     exp;
        global_params_t gexp;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                for (int i = 0; i < 3; i++) begin
                    v[i] = reg_data_t'($urandom);
                    host_write(1'(b), CH_BASE[i] + reg_addr_t'(c), v[i]);
                end
                exp = '{fnum: {v[1][1:0], v[0]}, block: v[1][4:2], kon: v[1][5],
                        cha: v[2][4], chb: v[2][5], chc: v[2][6], chd: v[2][7],
                        fb: v[2][3:1], cnt: v[2][0]};
                check_val($sformatf("ch_params[%0d][%0d]", b, c), 64'(ch_params[b][c]), 64'(exp));
            end
        end
        for (int i = 0; i < 7; i++) begin
            g[i] = reg_data_t'($urandom);
        end
        g[6] = g[6] & 8'h60; // masks only, timers stay stopped
        host_write(1'b0, ADDR_RHYTHM, g[0]);
        host_write(1'b0, ADDR_NTS, g[1]);
        host_write(1'b1, ADDR_TIMER_CTRL, g[2]); // connection select
        host_write(1'b1, ADDR_NEW, g[3]);
        host_write(1'b0, ADDR_TIMER1, g[4]);
        host_write(1'b0, ADDR_TIMER2, g[5]);
        host_write(1'b0, ADDR_TIMER_CTRL, g[6]);
        gexp                = '0;
        gexp.timer1         = g[4];
        gexp.timer2         = g[5];
        gexp.mt1            = g[6][6];
        gexp.mt2            = g[6][5];
        gexp.connection_sel = g[2][5:0];
        gexp.is_new         = g[3][0];
        gexp.nts            = g[1][6];
        {gexp.dam, gexp.dvb, gexp.ryt, gexp.bd, gexp.sd, gexp.tom, gexp.tc, gexp.hh} = g[0];
        check_val("glob", 64'(glob), 64'(gexp));
    endtask

    task automatic test_timer1();
        reg_data_t rd;
        host_write(1'b0, ADDR_TIMER1, 8'd250);
        host_write(1'b0, ADDR_TIMER_CTRL, 8'h01); // st1, unmasked
        wait_irq(6 * TICK_DIV + 16, "timer 1");
        host_read(rd);
        check_val("rdata", 64'(rd), 64'hC0);
        host_write(1'b0, ADDR_TIMER_CTRL, 8'h00); // stop timer 1
        host_write(1'b0, ADDR_TIMER_CTRL, 8'h80); // flag reset
        host_read(rd);
        check_val("rdata", 64'(rd), 64'h00);
    endtask

    task automatic test_mask_clear();
        reg_data_t rd;
        host_write(1'b0, ADDR_TIMER2, 8'd254);
        host_write(1'b0, ADDR_TIMER_CTRL, 8'h22); // st2 with mt2
        for (int i = 0; i < 8 * 4 * TICK_DIV; i++) begin // spans four overflows
            @(negedge clk);
            check_val("irq", 64'(irq), 64'd0);
        end
        host_read(rd);
        check_val("rdata", 64'(rd), 64'h00);
        host_write(1'b0, ADDR_TIMER_CTRL, 8'h02); // unmask, no new start edge
        wait_irq(4 * 4 * TICK_DIV + 16, "timer 2");
        host_read(rd);
        check_val("rdata", 64'(rd), 64'hA0);
        host_write(1'b0, ADDR_TIMER_CTRL, 8'h80);
        check_val("irq", 64'(irq), 64'd0);
        host_read(rd);
        check_val("rdata", 64'(rd), 64'h00);
        check_val("glob.mt1/mt2/st1/st2", 64'({glob.mt1, glob.mt2, glob.st1, glob.st2}),
                  64'b0001); // reg 04 untouched by the reset write
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        req         = 1'b0;
        host_req    = '0;
        err_cnt     = 0;
        timeout_cnt = 0;
        chk_cnt     = 0;
        seed        = 32'h90f610f8;
        void'($urandom(seed));
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_op_map();
        test_ch_glob();
        test_timer1();
        test_mask_clear();
        $display("checks: %0d, errors: %0d, timeouts: %0d", chk_cnt, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end
endmodule

//--- flist.f
rtl/opl3_pkg.sv
rtl/host_if_ctrl.sv
rtl/reg_store.sv
rtl/register_file.sv
rtl/opl3_timers.sv
rtl/opl3_regs_top.sv
testbench/opl3_regs_assert.sv
testbench/tb_opl3_regs.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_opl3_regs
FLIST      = flist.f
OBJ_DIR    = obj_dir
PASS_MSG   = All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
